// ==== run.sh ====
#!/usr/bin/env bash
# build the dfpRound testbench with Verilator, run it, check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f tb.f \
	--top-module dfpRoundTb \
	-o dfpRoundSim

# a stopped simulation still leaves its log for the search below
./obj_dir/dfpRoundSim | tee sim.log

if grep -qx "sim passed" sim.log; then
	echo "simulation result: pass"
	exit 0
fi

echo "simulation result: fail"
exit 1

// ==== src/bcdAddN.sv ====
// combinational ripple BCD adder, digits set by parameter
// operands must be valid BCD, digits above 9 give undefined sums
// carry ripples through every digit, so long chains are slow

`timescale 1ns/1ps

module bcdAddN #(
	// number of BCD digits per operand
	parameter int digits = 8
) (
	input  logic                  ci,
	input  logic [digits*4-1:0]   a,
	input  logic [digits*4-1:0]   b,
	output logic [digits*4-1:0]   sum,
	output logic                  co
);

	// ------------------------------
	// digit carry chain
	// ------------------------------

	// carry[k] enters digit k, carry[digits] leaves the top digit
	logic [digits:0] carry;

	assign carry[0] = ci;

	for (genvar k = 0; k < digits; k++) begin : gDigit
		// plain binary sum of one digit pair, at most 9 + 9 + 1 = 19
		logic [4:0] raw;

		assign raw = {1'b0, a[k*4 +: 4]} + {1'b0, b[k*4 +: 4]} + {4'b0, carry[k]};

		// anything past 9 wraps to the next decimal digit
		assign carry[k+1] = (raw > 5'd9);

		// add six to skip the six unused codes A..F
		// the overflow out of bit 3 is the decimal carry above
		assign sum[k*4 +: 4] = carry[k+1] ? raw[3:0] + 4'd6 : raw[3:0];
	end

	// carry out of the most significant digit
	assign co = carry[digits];

endmodule

// ==== src/dfpPkg.sv ====
// shared constants for the decimal floating-point rounding unit
// operands are BCD, eight mantissa digits plus one guard digit
// status nibble carries sign, NaN and infinity flags

package dfpPkg;

	// ------------------------------
	// digit counts and field widths
	// ------------------------------

	// mantissa digits, not counting the guard digit
	localparam int mantDigits = 8;
	localparam int expDigits = 4;

	// status nibble, upper bit reserved
	localparam int statWidth = 4;

	localparam int mantWidth = mantDigits * 4;
	localparam int expWidth = expDigits * 4;

	// input bus: status, exponent, mantissa, guard digit
	localparam int inWidth = statWidth + expWidth + mantWidth + 4;
	// output bus: status, exponent, mantissa
	localparam int outWidth = statWidth + expWidth + mantWidth;

	// ------------------------------
	// rounding modes
	// ------------------------------

	// codes 5 to 7 are unused and truncate like roundDown
	localparam logic [2:0] roundCeiling = 3'd0;
	localparam logic [2:0] roundFloor = 3'd1;
	localparam logic [2:0] roundHalfUp = 3'd2;
	localparam logic [2:0] roundHalfEven = 3'd3;
	localparam logic [2:0] roundDown = 3'd4;

	// ------------------------------
	// status nibble bits
	// ------------------------------

	// sign set means negative
	localparam int statSign = 2;
	localparam int statNan = 1;
	localparam int statInf = 0;

	// exponent value reserved for infinity, BCD 9999
	localparam logic [expWidth-1:0] expInfinite = 16'h9999;

endpackage

// ==== src/dfpRound.sv ====
// decimal floating-point rounding unit, three pipeline stages
// ce is the only flow control, every register holds while it is low
// exponent zero follows the normal carry rule, no denormal handling

`timescale 1ns/1ps

module dfpRound
	import dfpPkg::*;
(
	input  logic                clk,
	input  logic                arstN,
	input  logic                ce,
	input  logic [2:0]          rm,
	input  logic [inWidth-1:0]  i,
	output logic [outWidth-1:0] o
);

	// ------------------------------
	// input fields
	// ------------------------------

	// i is status, exponent, mantissa, guard digit from the top
	logic [statWidth-1:0]         statIn;
	logic [expWidth+mantWidth-1:0] expMantIn;
	logic [3:0]                   lastDigit;
	logic [3:0]                   guardDigit;

	assign statIn = i[inWidth-1 -: statWidth];
	assign expMantIn = i[inWidth-statWidth-1 -: expWidth+mantWidth];
	assign lastDigit = i[7:4];
	assign guardDigit = i[3:0];

	// ------------------------------
	// stage 1
	// ------------------------------

	logic                          rnd;
	logic [expWidth+mantWidth-1:0] expMant1;
	logic [statWidth-1:0]          stat3;

	roundDecide uDecide (
		.clk(clk), .arstN(arstN), .ce(ce),
		.rm(rm), .stat(statIn),
		.lastDigit(lastDigit), .guardDigit(guardDigit),
		.rnd(rnd)
	);

	// exponent and mantissa line up with rnd
	pipeDelay #(.T(logic [expWidth+mantWidth-1:0]), .depth(1)) uExpMantDly (
		.clk(clk), .arstN(arstN), .ce(ce), .d(expMantIn), .q(expMant1)
	);

	// status waits for the stage 3 selection
	pipeDelay #(.T(logic [statWidth-1:0]), .depth(2)) uStatDly (
		.clk(clk), .arstN(arstN), .ce(ce), .d(statIn), .q(stat3)
	);

	logic [mantWidth-1:0] mantSum;
	logic                 mantCarry;
	logic [expWidth-1:0]  expInc;

	// rounding adds rnd in at the lowest digit
	bcdAddN #(.digits(mantDigits)) uMantAdd (
		.ci(rnd), .a(expMant1[mantWidth-1:0]), .b('0),
		.sum(mantSum), .co(mantCarry)
	);

	// exponent plus one, used only on a mantissa carry
	bcdAddN #(.digits(expDigits)) uExpAdd (
		.ci(1'b1), .a(expMant1[expWidth+mantWidth-1:mantWidth]), .b('0),
		.sum(expInc), .co()
	);

	// ------------------------------
	// stages 2 and 3
	// ------------------------------

	logic [mantWidth-1:0] mantOut;
	logic [expWidth-1:0]  expOut;
	logic [statWidth-1:0] statOut;

	mantissaFixup uFixup (
		.clk(clk), .arstN(arstN), .ce(ce), .rnd(rnd),
		.mantIn(expMant1[mantWidth-1:0]),
		.expIn(expMant1[expWidth+mantWidth-1:mantWidth]),
		.mantSum(mantSum), .mantCarry(mantCarry), .expInc(expInc),
		.statIn(stat3),
		.mantOut(mantOut), .expOut(expOut), .statOut(statOut)
	);

	assign o = {statOut, expOut, mantOut};

endmodule

// ==== src/mantissaFixup.sv ====
// stages 2 and 3, registers the adder results then picks the output
// a mantissa carry renormalizes to 1 followed by zeros
// an exponent reaching 9999 gives infinity with a zero mantissa

`timescale 1ns/1ps

module mantissaFixup
	import dfpPkg::*;
(
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 ce,
	input  logic                 rnd,
	input  logic [mantWidth-1:0] mantIn,
	input  logic [expWidth-1:0]  expIn,
	input  logic [mantWidth-1:0] mantSum,
	input  logic                 mantCarry,
	input  logic [expWidth-1:0]  expInc,
	input  logic [statWidth-1:0] statIn,
	output logic [mantWidth-1:0] mantOut,
	output logic [expWidth-1:0]  expOut,
	output logic [statWidth-1:0] statOut
);

	// ------------------------------
	// stage 2 registers
	// ------------------------------

	logic [mantWidth-1:0] mantIn2;
	logic [expWidth-1:0]  expIn2;
	logic [mantWidth-1:0] mantSum2;
	logic                 carry2;
	logic [expWidth-1:0]  expInc2;
	logic                 rnd2;

	// rounded and unrounded values kept side by side
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			mantIn2 <= '0;
			expIn2 <= '0;
			mantSum2 <= '0;
			carry2 <= 1'b0;
			expInc2 <= '0;
			rnd2 <= 1'b0;
		end else if (ce) begin
			mantIn2 <= mantIn;
			expIn2 <= expIn;
			mantSum2 <= mantSum;
			carry2 <= mantCarry;
			expInc2 <= expInc;
			rnd2 <= rnd;
		end
	end

	// ------------------------------
	// stage 3 selection
	// ------------------------------

	logic [mantWidth-1:0] mantNext;
	logic [expWidth-1:0]  expNext;
	logic [statWidth-1:0] statNext;

	always_comb begin
		// default is the unrounded value
		mantNext = mantIn2;
		expNext = expIn2;
		statNext = statIn;
		if (rnd2) begin
			if (!carry2) begin
				// no digit overflow, exponent unchanged
				mantNext = mantSum2;
			end else if (expInc2 == expInfinite) begin
				// overflow into the reserved exponent
				mantNext = '0;
				expNext = expInc2;
				statNext[statInf] = 1'b1;
			end else begin
				// new leading digit, shift right by one digit
				mantNext = {4'h1, mantSum2[mantWidth-1:4]};
				expNext = expInc2;
			end
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			mantOut <= '0;
			expOut <= '0;
			statOut <= '0;
		end else if (ce) begin
			mantOut <= mantNext;
			expOut <= expNext;
			statOut <= statNext;
		end
	end

endmodule

// ==== src/pipeDelay.sv ====
// clock-enabled delay line, payload type and depth set by parameters
// depth must be at least 1, every stage clears to zero on reset

`timescale 1ns/1ps

module pipeDelay #(
	parameter type T = logic [7:0],
	parameter int depth = 1
) (
	input  logic clk,
	input  logic arstN,
	input  logic ce,
	input  T     d,
	output T     q
);

	// stage 0 is fed from d, last stage drives q
	T stages [depth];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int k = 0; k < depth; k++) begin
				stages[k] <= '0;
			end
		end else if (ce) begin
			// whole chain advances together, holds while ce is low
			stages[0] <= d;
			for (int k = 1; k < depth; k++) begin
				stages[k] <= stages[k-1];
			end
		end
	end

	assign q = stages[depth-1];

endmodule

// ==== src/roundDecide.sv ====
// round-up decision for one guard digit, registered under ce
// NaN and infinity inputs are never rounded
// unused mode codes truncate

`timescale 1ns/1ps

module roundDecide
	import dfpPkg::*;
(
	input  logic                 clk,
	input  logic                 arstN,
	input  logic                 ce,
	input  logic [2:0]           rm,
	input  logic [statWidth-1:0] stat,
	input  logic [3:0]           lastDigit,
	input  logic [3:0]           guardDigit,
	output logic                 rnd
);

	// ------------------------------
	// decision logic
	// ------------------------------

	logic rndNext;
	logic special;
	logic negative;
	logic guardNonZero;

	// special values pass through as they are
	assign special = stat[statNan] | stat[statInf];
	assign negative = stat[statSign];
	assign guardNonZero = (guardDigit != 4'd0);

	always_comb begin
		rndNext = 1'b0;
		if (!special) begin
			case (rm)
				// toward +inf, only positive values grow
				roundCeiling:  rndNext = guardNonZero & ~negative;
				// toward -inf, magnitude grows for negative values
				roundFloor:    rndNext = guardNonZero & negative;
				roundHalfUp:   rndNext = (guardDigit >= 4'd5);
				// exact tie goes to the even neighbour
				roundHalfEven: begin
					if (guardDigit == 4'd5) begin
						rndNext = lastDigit[0];
					end else begin
						rndNext = (guardDigit > 4'd5);
					end
				end
				roundDown:     rndNext = 1'b0;
				// codes 5..7 behave like truncation
				default:       rndNext = 1'b0;
			endcase
		end
	end

	// ------------------------------
	// stage 1 register
	// ------------------------------

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rnd <= 1'b0;
		end else if (ce) begin
			rnd <= rndNext;
		end
	end

endmodule

// ==== tb.f ====
src/dfpPkg.sv
src/bcdAddN.sv
src/pipeDelay.sv
src/roundDecide.sv
src/mantissaFixup.sv
src/dfpRound.sv
tb/dfpRound_sva.sv
tb/dfpRoundTb.sv

// ==== tb/dfpRoundTb.sv ====
// testbench for dfpRound, a table of rows applied back to back with ce
// expected values are worked out by hand from the rounding rules
// inputs change on the falling edge and outputs are sampled there too

`timescale 1ns/1ps

module dfpRoundTb
	import dfpPkg::*;
;

	logic                clk;
	logic                arstN;
	logic                ce;
	logic [2:0]          rm;
	logic [inWidth-1:0]  i;
	logic [outWidth-1:0] o;

	// ------------------------------
	// stimulus and expected table
	// ------------------------------

	logic [2:0]           rmTab[$];
	logic [statWidth-1:0] statTab[$];
	logic [expWidth-1:0]  expTab[$];
	logic [mantWidth-1:0] mantTab[$];
	logic [3:0]           guardTab[$];
	logic [statWidth-1:0] expStatTab[$];
	logic [expWidth-1:0]  expExpTab[$];
	logic [mantWidth-1:0] expMantTab[$];

	// rows in flight and the enabled edges each has seen
	int pendRow[$];
	int pendAge[$];

	int errors;
	int rowsChecked;
	int nextRow;
	int cycle;
	int stallLeft;
	logic [outWidth-1:0] heldO;

	// the stall sits in front of this row
	localparam int stallRow = 8;
	// length of the stall in cycles
	localparam int stallLen = 4;
	// limit on the streaming loop
	localparam int maxCycles = 200;

	dfpRound dut (
		.clk(clk), .arstN(arstN), .ce(ce), .rm(rm), .i(i), .o(o)
	);

	always #4 clk = ~clk;

	task automatic addRow(input logic [2:0] m, input logic [3:0] s, input logic [15:0] e,
			input logic [31:0] mant, input logic [3:0] g, input logic [3:0] eS,
			input logic [15:0] eE, input logic [31:0] eM);
		rmTab.push_back(m);
		statTab.push_back(s);
		expTab.push_back(e);
		mantTab.push_back(mant);
		guardTab.push_back(g);
		expStatTab.push_back(eS);
		expExpTab.push_back(eE);
		expMantTab.push_back(eM);
	endtask

	task automatic driveRow(input int r);
		rm = rmTab[r];
		i = {statTab[r], expTab[r], mantTab[r], guardTab[r]};
	endtask

	// compare the three output fields against row r
	task automatic checkRow(input int r);
		logic [statWidth-1:0] gotStat;
		logic [expWidth-1:0]  gotExp;
		logic [mantWidth-1:0] gotMant;
		gotStat = o[outWidth-1 -: statWidth];
		gotExp = o[mantWidth +: expWidth];
		gotMant = o[mantWidth-1:0];
		rowsChecked++;
		if (gotStat !== expStatTab[r]) begin
			$display("ERROR o status, row %0d: expected %h, got %h", r, expStatTab[r], gotStat);
			errors++;
		end
		if (gotExp !== expExpTab[r]) begin
			$display("ERROR o exponent, row %0d: expected %h, got %h", r, expExpTab[r], gotExp);
			errors++;
		end
		if (gotMant !== expMantTab[r]) begin
			$display("ERROR o mantissa, row %0d: expected %h, got %h", r, expMantTab[r], gotMant);
			errors++;
		end
	endtask

	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		ce = 1'b0;
		rm = 3'd0;
		i = '0;
		errors = 0;
		rowsChecked = 0;

		// mode, status, exponent, mantissa, guard, then expected status, exponent, mantissa
		addRow(roundCeiling, 4'h0, 16'h0100, 32'h12345678, 4'h3, 4'h0, 16'h0100, 32'h12345679);
		addRow(roundCeiling, 4'h4, 16'h0100, 32'h12345678, 4'h7, 4'h4, 16'h0100, 32'h12345678);
		addRow(roundCeiling, 4'h0, 16'h0000, 32'h00000001, 4'h0, 4'h0, 16'h0000, 32'h00000001);
		addRow(roundFloor, 4'h4, 16'h0200, 32'h00001239, 4'h3, 4'h4, 16'h0200, 32'h00001240);
		addRow(roundFloor, 4'h0, 16'h0300, 32'h55555555, 4'h7, 4'h0, 16'h0300, 32'h55555555);
		addRow(roundHalfUp, 4'h0, 16'h0001, 32'h11111119, 4'h5, 4'h0, 16'h0001, 32'h11111120);
		addRow(roundHalfUp, 4'h4, 16'h0002, 32'h22222222, 4'h3, 4'h4, 16'h0002, 32'h22222222);
		// half-even ties, even then odd last digit
		addRow(roundHalfEven, 4'h0, 16'h0003, 32'h33333332, 4'h5, 4'h0, 16'h0003, 32'h33333332);
		addRow(roundHalfEven, 4'h4, 16'h0003, 32'h33333333, 4'h5, 4'h4, 16'h0003, 32'h33333334);
		addRow(roundHalfEven, 4'h0, 16'h0004, 32'h44444440, 4'h7, 4'h0, 16'h0004, 32'h44444441);
		// below the tie an odd last digit stays
		addRow(roundHalfEven, 4'h0, 16'h0004, 32'h44444443, 4'h3, 4'h0, 16'h0004, 32'h44444443);
		addRow(roundDown, 4'h0, 16'h0005, 32'h66666666, 4'h7, 4'h0, 16'h0005, 32'h66666666);
		// unused mode code truncates
		addRow(3'd5, 4'h4, 16'h0006, 32'h77777777, 4'h7, 4'h4, 16'h0006, 32'h77777777);
		// carry renormalizes, exponent 0199 steps to 0200
		addRow(roundHalfUp, 4'h0, 16'h0199, 32'h99999999, 4'h7, 4'h0, 16'h0200, 32'h10000000);
		// 9998 plus a carry overflows to infinity
		addRow(roundCeiling, 4'h0, 16'h9998, 32'h99999999, 4'h3, 4'h1, 16'h9999, 32'h00000000);
		// NaN and infinity pass through
		addRow(roundCeiling, 4'h2, 16'h0050, 32'h12345678, 4'h7, 4'h2, 16'h0050, 32'h12345678);
		addRow(roundHalfUp, 4'h1, 16'h9999, 32'h00000000, 4'h9, 4'h1, 16'h9999, 32'h00000000);
		// exponent zero uses the normal carry rule
		addRow(roundFloor, 4'h4, 16'h0000, 32'h99999999, 4'h5, 4'h4, 16'h0001, 32'h10000000);
		// negative value with a zero guard is exact under floor
		addRow(roundFloor, 4'h4, 16'h0007, 32'h88888888, 4'h0, 4'h4, 16'h0007, 32'h88888888);

		// ------------------------------
		// reset, then ce held low
		// ------------------------------
		for (int k = 0; k < 5; k++) begin
			@(posedge clk);
		end
		@(negedge clk);
		arstN = 1'b1;
		driveRow(0);
		for (int k = 0; k < 4; k++) begin
			@(negedge clk);
			if (o !== '0) begin
				$display("ERROR o with ce low after reset: expected %h, got %h",
					{outWidth{1'b0}}, o);
				errors++;
			end
		end

		// ------------------------------
		// stream the table, with one stall
		// ------------------------------
		nextRow = 0;
		cycle = 0;
		stallLeft = stallLen;
		heldO = o;
		while ((nextRow < rmTab.size() || pendRow.size() != 0) && cycle < maxCycles) begin
			@(negedge clk);
			cycle++;
			// ce still holds the value the last rising edge used
			if (ce) begin
				for (int k = 0; k < pendAge.size(); k++) begin
					pendAge[k] = pendAge[k] + 1;
				end
			end else if (o !== heldO) begin
				$display("ERROR o during stall: expected %h, got %h", heldO, o);
				errors++;
			end
			// three enabled edges after its row, the oldest one is on o
			if (pendAge.size() != 0 && pendAge[0] == 3) begin
				checkRow(pendRow[0]);
				pendRow.delete(0);
				pendAge.delete(0);
			end
			if (nextRow == stallRow && stallLeft > 0) begin
				// the next row already waits on i while ce is low
				driveRow(stallRow);
				ce = 1'b0;
				heldO = o;
				stallLeft--;
			end else if (nextRow < rmTab.size()) begin
				driveRow(nextRow);
				ce = 1'b1;
				pendRow.push_back(nextRow);
				pendAge.push_back(0);
				nextRow++;
			end else begin
				// drain with zero filler
				ce = 1'b1;
				rm = 3'd0;
				i = '0;
			end
		end
		if (nextRow < rmTab.size() || pendRow.size() != 0) begin
			$display("timeout: the pipeline did not deliver every row within %0d cycles", maxCycles);
			errors++;
		end

		$display("rows checked %0d, errors %0d", rowsChecked, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== tb/dfpRound_sva.sv ====
// assertions bound onto dfpRound
// the sign check assumes reset stays high once released

`timescale 1ns/1ps

module dfpRoundSva
	import dfpPkg::*;
(
	input logic                clk,
	input logic                arstN,
	input logic                ce,
	input logic [inWidth-1:0]  i,
	input logic [outWidth-1:0] o,
	input logic                rnd
);

	// exponent and mantissa digits of o, status nibble left out
	for (genvar k = 0; k < expDigits + mantDigits; k++) begin : gDigit
		digitIsBcd: assert property (@(posedge clk) disable iff (!arstN)
			o[k*4 +: 4] <= 4'd9)
			else $error("output digit %0d holds a value above nine", k);
	end

	// special inputs never round
	specialNoRound: assert property (@(posedge clk) disable iff (!arstN)
		ce && (i[inWidth-statWidth+statNan] || i[inWidth-statWidth+statInf]) |=> !rnd)
		else $error("rnd set for a NaN or infinity input");

	// sign travels three enabled stages unchanged
	signFollows: assert property (@(posedge clk) disable iff (!arstN)
		$past(ce, 1) && $past(ce, 2) && $past(ce, 3) && $past(arstN, 3)
		|-> o[outWidth-statWidth+statSign] == $past(i[inWidth-statWidth+statSign], 3))
		else $error("output sign differs from the input sign three cycles back");

endmodule

bind dfpRound dfpRoundSva sva (
	.clk(clk), .arstN(arstN), .ce(ce), .i(i), .o(o), .rnd(rnd)
);
